//--- verilog/trace_pkg.sv
/* shared widths, structs, trigger states and register map of the trace core
   every module imports what it needs from here */
`default_nettype none

package trace_pkg;

   typedef logic [3:0]  trace_nibble_t;    // one trace sample
   typedef logic [31:0] trace_buf_t;       // last 8 nibbles, newest in low bits
   typedef logic [3:0]  reg_addr_t;
   typedef logic [31:0] reg_data_t;
   typedef logic [1:0]  rule_idx_t;        // up to 4 rules
   typedef logic [15:0] tstamp_t;          // free running event time
   typedef logic [19:0] trig_count_t;      // delay or width in cycles
   typedef logic [3:0]  pulse_num_t;       // pulses per train
   typedef logic [5:0]  fifo_cnt_t;        // holds 0 up to 32

   typedef struct packed {
      trace_buf_t pattern;
      trace_buf_t mask;                    // 1 means bit is compared
   } match_rule_t;

   typedef struct packed {
      logic        enable;
      trig_count_t delay;
      trig_count_t width;
      pulse_num_t  num_pulses;
   } trig_cfg_t;

   typedef struct packed {
      rule_idx_t rule;                     // lowest matching rule
      tstamp_t   tstamp;
   } trace_event_t;

   typedef enum logic [1:0] {
      IDLE,
      DELAY,
      PULSE
   } trig_state_t;

   // register map
   localparam reg_addr_t ADDR_CTRL       = 4'd0;
   localparam reg_addr_t ADDR_TRIG_DELAY = 4'd1;
   localparam reg_addr_t ADDR_TRIG_WIDTH = 4'd2;
   localparam reg_addr_t ADDR_NUM_PULSES = 4'd3;
   localparam reg_addr_t ADDR_STATUS     = 4'd4;
   localparam reg_addr_t ADDR_EVENT      = 4'd5;   // read pops the FIFO
   localparam reg_addr_t ADDR_RULE_BASE  = 4'd8;   // pattern then mask per rule

   localparam int CTRL_TRIG_EN  = 8;       // CTRL bit positions
   localparam int CTRL_ARM      = 9;       // write only
   localparam int STAT_EMPTY    = 8;       // STATUS bit positions
   localparam int STAT_OVERFLOW = 9;
   localparam int STAT_BUSY     = 10;

endpackage

`default_nettype wire

//--- verilog/trace_regs.sv
/* configuration and status register bank driven by plain read/write strobes
   writes land on the strobe edge, read data is registered one cycle later */
`default_nettype none

module trace_regs #(
   parameter int pMATCH_RULES = 4
) (
   input  wire logic                    trace_clk,
   input  wire logic                    rst_n,
   input  wire logic                    reg_write,     // write strobe
   input  wire logic                    reg_read,      // read strobe
   input  wire trace_pkg::reg_addr_t    reg_addr,
   input  wire trace_pkg::reg_data_t    reg_wdata,
   output trace_pkg::reg_data_t         reg_rdata,     // valid cycle after reg_read
   output trace_pkg::match_rule_t       rules [pMATCH_RULES],
   output logic [pMATCH_RULES-1:0]      rule_en,
   output trace_pkg::trig_cfg_t         trig_cfg,
   output logic                         arm_pulse,     // single cycle, from CTRL write
   output logic                         event_pop,     // FIFO read on event access
   input  wire trace_pkg::trace_event_t event_head,
   input  wire trace_pkg::fifo_cnt_t    fifo_count,
   input  wire logic                    fifo_empty,
   input  wire logic                    fifo_overflow,
   input  wire logic                    trig_busy
);
   import trace_pkg::*;

   reg_data_t rd_mux;                                  // read data before the flop

   // address of a rule's pattern or mask word
   function automatic reg_addr_t rule_addr(int idx, logic is_mask);
      return reg_addr_t'(int'(ADDR_RULE_BASE) + 2 * idx + int'(is_mask));
   endfunction

   assign arm_pulse = reg_write && reg_addr == ADDR_CTRL && reg_wdata[CTRL_ARM];
   assign event_pop = reg_read && reg_addr == ADDR_EVENT && !fifo_empty;

   always_ff @(posedge trace_clk or negedge rst_n) begin
      if (!rst_n) begin
         rule_en  <= '0;
         trig_cfg <= '0;
         for (int i = 0; i < pMATCH_RULES; i++) begin
            rules[i] <= '0;
         end
      end else if (reg_write) begin
         case (reg_addr)
            ADDR_CTRL: begin
               rule_en         <= reg_wdata[pMATCH_RULES-1:0];
               trig_cfg.enable <= reg_wdata[CTRL_TRIG_EN];   // arm bit not stored
            end
            ADDR_TRIG_DELAY: trig_cfg.delay      <= reg_wdata[$bits(trig_count_t)-1:0];
            ADDR_TRIG_WIDTH: trig_cfg.width      <= reg_wdata[$bits(trig_count_t)-1:0];
            ADDR_NUM_PULSES: trig_cfg.num_pulses <= reg_wdata[$bits(pulse_num_t)-1:0];
            default: begin
               for (int i = 0; i < pMATCH_RULES; i++) begin
                  if (reg_addr == rule_addr(i, 1'b0)) rules[i].pattern <= reg_wdata;
                  if (reg_addr == rule_addr(i, 1'b1)) rules[i].mask    <= reg_wdata;
               end
            end
         endcase
      end
   end

   // read mux, unmapped addresses fall through as zero
   always_comb begin
      rd_mux = '0;
      case (reg_addr)
         ADDR_CTRL: begin
            rd_mux[pMATCH_RULES-1:0] = rule_en;
            rd_mux[CTRL_TRIG_EN]     = trig_cfg.enable;
         end
         ADDR_TRIG_DELAY: rd_mux[$bits(trig_count_t)-1:0] = trig_cfg.delay;
         ADDR_TRIG_WIDTH: rd_mux[$bits(trig_count_t)-1:0] = trig_cfg.width;
         ADDR_NUM_PULSES: rd_mux[$bits(pulse_num_t)-1:0]  = trig_cfg.num_pulses;
         ADDR_STATUS: begin
            rd_mux[$bits(fifo_cnt_t)-1:0] = fifo_count;
            rd_mux[STAT_EMPTY]            = fifo_empty;
            rd_mux[STAT_OVERFLOW]         = fifo_overflow;
            rd_mux[STAT_BUSY]             = trig_busy;
         end
         ADDR_EVENT: begin
            if (!fifo_empty) rd_mux[$bits(trace_event_t)-1:0] = event_head;
         end
         default: begin
            for (int i = 0; i < pMATCH_RULES; i++) begin
               if (reg_addr == rule_addr(i, 1'b0)) rd_mux = rules[i].pattern;
               if (reg_addr == rule_addr(i, 1'b1)) rd_mux = rules[i].mask;
            end
         end
      endcase
   end

   always_ff @(posedge trace_clk or negedge rst_n) begin
      if (!rst_n) begin
         reg_rdata <= '0;
      end else if (reg_read) begin
         reg_rdata <= rd_mux;                          // held until next read
      end
   end

endmodule

`default_nettype wire

//--- verilog/trace_matcher.sv
/* trace front end, shifts 4-bit trace samples into a 32-bit window
   and flags the lowest enabled rule whose masked pattern matches */
`default_nettype none

module trace_matcher #(
   parameter int pMATCH_RULES = 4
) (
   input  wire logic                     trace_clk,
   input  wire logic                     rst_n,
   input  wire logic                     trcena,       // trace sample valid
   input  wire trace_pkg::trace_nibble_t trace_data,
   input  wire trace_pkg::match_rule_t   rules [pMATCH_RULES],
   input  wire logic [pMATCH_RULES-1:0]  rule_en,
   output logic                          match_hit,    // one cycle per matching shift
   output trace_pkg::rule_idx_t          match_rule
);
   import trace_pkg::*;

   localparam int BUF_W = $bits(trace_buf_t);
   localparam int NIB_W = $bits(trace_nibble_t);

   trace_buf_t              buffer;                    // newest nibble in low bits
   logic                    shifted;                   // buffer took a nibble last edge
   logic [pMATCH_RULES-1:0] rule_hit;
   rule_idx_t               first_hit;

   // masked compare, per rule
   always_comb begin
      for (int i = 0; i < pMATCH_RULES; i++) begin
         rule_hit[i] = rule_en[i] && ((buffer ^ rules[i].pattern) & rules[i].mask) == '0;
      end
   end

   // lowest numbered rule wins
   always_comb begin
      first_hit = '0;
      for (int i = pMATCH_RULES - 1; i >= 0; i--) begin
         if (rule_hit[i]) first_hit = rule_idx_t'(i);
      end
   end

   always_ff @(posedge trace_clk or negedge rst_n) begin
      if (!rst_n) begin
         buffer    <= '0;
         shifted   <= 1'b0;
         match_hit <= 1'b0;
      end else begin
         if (trcena) begin
            buffer <= {buffer[BUF_W-NIB_W-1:0], trace_data};   // hold when idle
         end
         shifted   <= trcena;
         match_hit <= shifted && |rule_hit;            // only fresh windows count
      end
   end

   always_ff @(posedge trace_clk) begin
      if (shifted && |rule_hit) begin
         match_rule <= first_hit;                      // qualified by match_hit
      end
   end

endmodule

`default_nettype wire

//--- verilog/event_capture.sv
/* timestamped event recorder, a circular FIFO of rule/time entries
   cleared and armed by the arm pulse, drops entries once full */
`default_nettype none

module event_capture #(
   parameter int pFIFO_DEPTH = 16
) (
   input  wire logic                 trace_clk,
   input  wire logic                 rst_n,
   input  wire logic                 arm_pulse,        // clears FIFO and time
   input  wire logic                 match_hit,
   input  wire trace_pkg::rule_idx_t match_rule,
   input  wire logic                 event_pop,
   output trace_pkg::trace_event_t   event_head,       // oldest entry
   output trace_pkg::fifo_cnt_t      fifo_count,
   output logic                      fifo_empty,
   output logic                      fifo_overflow     // sticky until next arm
);
   import trace_pkg::*;

   localparam int PTR_W = $clog2(pFIFO_DEPTH);

   trace_event_t     mem [pFIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;                           // wraps, depth is 2^n
   logic [PTR_W-1:0] rd_ptr;
   tstamp_t          now;                              // free running time
   logic             armed;
   logic             fifo_full;
   logic             do_write;
   logic             do_pop;

   assign fifo_empty = fifo_count == '0;
   assign fifo_full  = fifo_count == fifo_cnt_t'(pFIFO_DEPTH);
   assign do_write   = armed && match_hit && !fifo_full && !arm_pulse;
   assign do_pop     = event_pop && !fifo_empty && !arm_pulse;
   assign event_head = mem[rd_ptr];

   always_ff @(posedge trace_clk or negedge rst_n) begin
      if (!rst_n) begin
         now           <= '0;
         armed         <= 1'b0;
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         fifo_count    <= '0;
         fifo_overflow <= 1'b0;
      end else if (arm_pulse) begin
         now           <= '0;                          // zero on the cycle after arm
         armed         <= 1'b1;
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         fifo_count    <= '0;
         fifo_overflow <= 1'b0;
      end else begin
         now <= now + 1'b1;
         if (do_write) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         if (do_write && !do_pop) begin
            fifo_count <= fifo_count + 1'b1;
         end else if (do_pop && !do_write) begin
            fifo_count <= fifo_count - 1'b1;
         end
         if (armed && match_hit && fifo_full) begin
            fifo_overflow <= 1'b1;                     // entry lost
         end
      end
   end

   // entry storage, time taken on the same edge as the match
   always_ff @(posedge trace_clk) begin
      if (do_write) begin
         mem[wr_ptr] <= '{rule: match_rule, tstamp: now};
      end
   end

endmodule

`default_nettype wire

//--- verilog/pulse_trigger.sv
/* pulse train generator started by a trace match
   one delay and one width apply to every pulse of the train */
`default_nettype none

module pulse_trigger (
   input  wire logic                 trace_clk,
   input  wire logic                 rst_n,
   input  wire logic                 match_hit,
   input  wire trace_pkg::trig_cfg_t trig_cfg,
   output logic                      trig_out,
   output logic                      trig_busy         // train in progress
);
   import trace_pkg::*;

   trig_state_t state;
   trig_count_t cnt;                                   // cycles left in phase
   pulse_num_t  pulses_left;                           // includes current pulse
   logic        delay_zero;
   logic        start;

   assign delay_zero = trig_cfg.delay == '0;
   assign start      = match_hit && trig_cfg.enable && trig_cfg.num_pulses != '0;
   assign trig_busy  = state != IDLE;

   always_ff @(posedge trace_clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= IDLE;
         trig_out    <= 1'b0;
         cnt         <= '0;
         pulses_left <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin
                  pulses_left <= trig_cfg.num_pulses;
                  if (delay_zero) begin
                     state    <= PULSE;                // rise on the match edge
                     trig_out <= 1'b1;
                     cnt      <= trig_cfg.width;
                  end else begin
                     state <= DELAY;
                     cnt   <= trig_cfg.delay;
                  end
               end
            end
            DELAY: begin
               if (cnt <= trig_count_t'(1)) begin
                  state    <= PULSE;
                  trig_out <= 1'b1;
                  cnt      <= trig_cfg.width;
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            PULSE: begin
               if (cnt > trig_count_t'(1)) begin
                  cnt <= cnt - 1'b1;                   // width of 0 acts as 1
               end else if (pulses_left <= pulse_num_t'(1)) begin
                  state    <= IDLE;                    // last pulse done
                  trig_out <= 1'b0;
               end else begin
                  pulses_left <= pulses_left - 1'b1;
                  if (delay_zero) begin
                     cnt <= trig_cfg.width;            // back to back, stays high
                  end else begin
                     state    <= DELAY;
                     trig_out <= 1'b0;
                     cnt      <= trig_cfg.delay;
                  end
               end
            end
            default: begin
               state    <= IDLE;
               trig_out <= 1'b0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/trace_top.sv
/* top level of the trace matching core, all in the trace_clk domain
   ties the register bank, matcher, event FIFO and pulse trigger together */
`default_nettype none

module trace_top #(
   parameter int pMATCH_RULES = 4,                     // 1 to 4
   parameter int pFIFO_DEPTH  = 16                     // power of two, 4 to 32
) (
   input  wire logic                     trace_clk,
   input  wire logic                     rst_n,
   input  wire logic                     trcena,
   input  wire trace_pkg::trace_nibble_t trace_data,
   input  wire logic                     reg_write,
   input  wire logic                     reg_read,
   input  wire trace_pkg::reg_addr_t     reg_addr,
   input  wire trace_pkg::reg_data_t     reg_wdata,
   output trace_pkg::reg_data_t          reg_rdata,
   output logic                          trig_out
);
   import trace_pkg::*;

   match_rule_t             rules [pMATCH_RULES];      // config to matcher
   logic [pMATCH_RULES-1:0] rule_en;
   trig_cfg_t               trig_cfg;
   logic                    arm_pulse;
   logic                    event_pop;
   trace_event_t            event_head;                // FIFO to register bank
   fifo_cnt_t               fifo_count;
   logic                    fifo_empty;
   logic                    fifo_overflow;
   logic                    trig_busy;
   logic                    match_hit;                 // matcher to capture and trigger
   rule_idx_t               match_rule;

   trace_regs #(
      .pMATCH_RULES  (pMATCH_RULES)
   ) regs_i (
      .trace_clk     (trace_clk),
      .rst_n         (rst_n),
      .reg_write     (reg_write),
      .reg_read      (reg_read),
      .reg_addr      (reg_addr),
      .reg_wdata     (reg_wdata),
      .reg_rdata     (reg_rdata),
      .rules         (rules),
      .rule_en       (rule_en),
      .trig_cfg      (trig_cfg),
      .arm_pulse     (arm_pulse),
      .event_pop     (event_pop),
      .event_head    (event_head),
      .fifo_count    (fifo_count),
      .fifo_empty    (fifo_empty),
      .fifo_overflow (fifo_overflow),
      .trig_busy     (trig_busy)
   );

   trace_matcher #(
      .pMATCH_RULES  (pMATCH_RULES)
   ) matcher_i (
      .trace_clk     (trace_clk),
      .rst_n         (rst_n),
      .trcena        (trcena),
      .trace_data    (trace_data),
      .rules         (rules),
      .rule_en       (rule_en),
      .match_hit     (match_hit),
      .match_rule    (match_rule)
   );

   event_capture #(
      .pFIFO_DEPTH   (pFIFO_DEPTH)
   ) capture_i (
      .trace_clk     (trace_clk),
      .rst_n         (rst_n),
      .arm_pulse     (arm_pulse),
      .match_hit     (match_hit),
      .match_rule    (match_rule),
      .event_pop     (event_pop),
      .event_head    (event_head),
      .fifo_count    (fifo_count),
      .fifo_empty    (fifo_empty),
      .fifo_overflow (fifo_overflow)
   );

   pulse_trigger trigger_i (
      .trace_clk     (trace_clk),
      .rst_n         (rst_n),
      .match_hit     (match_hit),
      .trig_cfg      (trig_cfg),
      .trig_out      (trig_out),
      .trig_busy     (trig_busy)
   );

endmodule

`default_nettype wire

//--- dv/trace_top_assert.sv
/* concurrent checks on the pulse trigger and the event FIFO
   bound into both blocks, pTRIG picks which group is active */
`default_nettype none

module trace_top_assert #(
   parameter bit pTRIG  = 1'b1,
   parameter int pDEPTH = 16
) (
   input wire logic                  clk,
   input wire logic                  rst_n,
   input wire trace_pkg::trig_state_t state,
   input wire logic                  trig_out,
   input wire trace_pkg::fifo_cnt_t  fifo_count,
   input wire logic                  fifo_overflow
);
   import trace_pkg::*;

   if (pTRIG) begin : g_trig
      a_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
         state == IDLE |-> !trig_out)
         else $error("trig_out high while trigger is idle");
   end else begin : g_fifo
      a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
         fifo_count <= fifo_cnt_t'(pDEPTH))
         else $error("FIFO count above depth");
      a_ovf_full: assert property (@(posedge clk) disable iff (!rst_n)
         $rose(fifo_overflow) |-> $past(fifo_count) == fifo_cnt_t'(pDEPTH))
         else $error("overflow set while FIFO not full");   // only a full FIFO drops
   end

endmodule

bind pulse_trigger trace_top_assert #(.pTRIG(1'b1)) trig_chk (
   .clk           (trace_clk),
   .rst_n         (rst_n),
   .state         (state),
   .trig_out      (trig_out),
   .fifo_count    (trace_pkg::fifo_cnt_t'(0)),
   .fifo_overflow (1'b0)
);

bind event_capture trace_top_assert #(.pTRIG(1'b0), .pDEPTH(pFIFO_DEPTH)) fifo_chk (
   .clk           (trace_clk),
   .rst_n         (rst_n),
   .state         (trace_pkg::IDLE),
   .trig_out      (1'b0),
   .fifo_count    (fifo_count),
   .fifo_overflow (fifo_overflow)
);

`default_nettype wire

//--- dv/trace_top_tb.sv
/* table driven testbench for the trace matching core
   runs register, match, timestamp, pulse train and FIFO overflow tests */
`default_nettype none

module trace_top_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import trace_pkg::*;

   localparam int RULES     = 4;
   localparam int DEPTH     = 16;
   localparam int NUM_ROWS  = 6;
   localparam int WD_CYCLES = (NUM_ROWS + 2) * 200;    // table rows plus reset and overflow

   typedef struct packed {
      rule_idx_t   ra;                                 // first rule written
      trace_buf_t  pa;
      trace_buf_t  ma;
      rule_idx_t   rb;                                 // second rule written
      trace_buf_t  pb;
      trace_buf_t  mb;
      logic [3:0]  en;
      logic        trig_en;
      trig_count_t delay;
      trig_count_t width;
      pulse_num_t  npulses;
      trace_buf_t  seq;                                // sent msb nibble first
      int          reps;
      int          gap;                                // filler between repeats
      int          exp_events;
      rule_idx_t   exp_rule;
   } row_t;

   localparam row_t ROWS [NUM_ROWS] = '{
      // masked rule 2, low half compared
      '{2'd2, 32'h0000_5A3C, 32'h0000_FFFF, 2'd2, 32'h0000_5A3C, 32'h0000_FFFF, 4'b0100,
        1'b0, 20'd0, 20'd0, 4'd0, 32'h1234_5A3C, 1, 0, 1, 2'd2},
      // rules 1 and 3 hit together, pulse train of 3
      '{2'd1, 32'hDEAD_BEEF, 32'hFFFF_FFFF, 2'd3, 32'h0000_BEEF, 32'h0000_FFFF, 4'b1010,
        1'b1, 20'd3, 20'd2, 4'd3, 32'hDEAD_BEEF, 1, 0, 1, 2'd1},
      // all rules off
      '{2'd0, 32'h1357_9BDF, 32'hFFFF_FFFF, 2'd0, 32'h1357_9BDF, 32'hFFFF_FFFF, 4'b0000,
        1'b1, 20'd1, 20'd1, 4'd2, 32'h1357_9BDF, 1, 0, 0, 2'd0},
      // two matches 13 edges apart
      '{2'd0, 32'h1357_9BDF, 32'hFFFF_FFFF, 2'd0, 32'h1357_9BDF, 32'hFFFF_FFFF, 4'b0001,
        1'b0, 20'd0, 20'd0, 4'd0, 32'h1357_9BDF, 2, 5, 2, 2'd0},
      // trigger enable cleared
      '{2'd3, 32'hCAFE_F00D, 32'hFFFF_FFFF, 2'd3, 32'hCAFE_F00D, 32'hFFFF_FFFF, 4'b1000,
        1'b0, 20'd2, 20'd3, 4'd2, 32'hCAFE_F00D, 1, 0, 1, 2'd3},
      // short delay and width
      '{2'd0, 32'h2468_ACE0, 32'hFFFF_FFFF, 2'd0, 32'h2468_ACE0, 32'hFFFF_FFFF, 4'b0001,
        1'b1, 20'd1, 20'd1, 4'd2, 32'h2468_ACE0, 1, 0, 1, 2'd0}
   };

   logic          trace_clk;
   logic          rst_n;
   logic          trcena;
   trace_nibble_t trace_data;
   logic          reg_write;
   logic          reg_read;
   reg_addr_t     reg_addr;
   reg_data_t     reg_wdata;
   reg_data_t     reg_rdata;
   logic          trig_out;

   int           cyc;                                  // rising edges so far
   int           seed;
   int           errors;
   int           last_wr_edge;                         // edge that took the last write
   int           arm_edge;
   int           first_hit_edge;
   trace_buf_t   m_buf;                                // model of the shift buffer
   trace_buf_t   m_pat [RULES];
   trace_buf_t   m_mask [RULES];
   logic [3:0]   m_en;
   logic         m_ovf;
   trace_event_t exp_ev [$];
   int           rise_q [$];                           // trig_out rise edges
   int           width_q [$];
   logic         trig_prev;

   trace_top #(
      .pMATCH_RULES (RULES),
      .pFIFO_DEPTH  (DEPTH)
   ) trace_top_i (
      .trace_clk  (trace_clk),
      .rst_n      (rst_n),
      .trcena     (trcena),
      .trace_data (trace_data),
      .reg_write  (reg_write),
      .reg_read   (reg_read),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_rdata  (reg_rdata),
      .trig_out   (trig_out)
   );

   initial begin
      trace_clk = 1'b0;
      cyc       = 0;
      forever begin
         #20 trace_clk = 1'b1;
         cyc++;
         #20 trace_clk = 1'b0;
      end
   end

   // pulse monitor, sampled mid cycle
   always @(negedge trace_clk) begin
      if (rst_n && trig_out && !trig_prev) begin
         rise_q.push_back(cyc);
         width_q.push_back(1);
      end else if (rst_n && trig_out) begin
         width_q[width_q.size() - 1] = width_q[width_q.size() - 1] + 1;
      end
      trig_prev = trig_out;
   end

   initial begin
      #(WD_CYCLES * 40);
      $display("watchdog timeout, the run took longer than its time limit");
      $display("Simulation failed");
      $fatal(1, "watchdog");
   end

   task automatic fail_now(string msg);
      errors++;
      $display("[ERROR] %0t ns: %s", $time, msg);
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_data(string what, reg_data_t got, reg_data_t exp);
      if (got !== exp) fail_now($sformatf("%s: got %h, expected %h", what, got, exp));
   endtask

   task automatic check_event(trace_event_t got, trace_event_t exp);
      if (got !== exp) begin
         fail_now($sformatf("event: got rule %0d time %0d, expected rule %0d time %0d",
                            got.rule, got.tstamp, exp.rule, exp.tstamp));
      end
   endtask

   task automatic check_trig(string what, pulse_num_t pnum, trig_count_t got, trig_count_t exp);
      if (got !== exp) fail_now($sformatf("%s, pulse %0d: got %0d, expected %0d",
                                          what, pnum, got, exp));
   endtask

   task automatic reg_wr(reg_addr_t addr, reg_data_t data);
      @(posedge trace_clk);
      #2;
      reg_write    = 1'b1;
      reg_addr     = addr;
      reg_wdata    = data;
      last_wr_edge = cyc + 1;
      @(posedge trace_clk);
      #2;
      reg_write = 1'b0;
   endtask

   task automatic reg_rd(reg_addr_t addr, output reg_data_t data);
      @(posedge trace_clk);
      #2;
      reg_read = 1'b1;
      reg_addr = addr;
      @(posedge trace_clk);
      #2;
      reg_read = 1'b0;
      data     = reg_rdata;                            // registered on that edge
   endtask

   // lowest enabled rule matching a window, -1 if none
   function automatic int model_match(trace_buf_t w);
      for (int i = 0; i < RULES; i++) begin
         if (m_en[i] && ((w ^ m_pat[i]) & m_mask[i]) == 32'h0) return i;
      end
      return -1;
   endfunction

   task automatic set_rule(rule_idx_t r, trace_buf_t pat, trace_buf_t mask);
      reg_wr(reg_addr_t'(int'(ADDR_RULE_BASE) + 2 * int'(r)), pat);
      reg_wr(reg_addr_t'(int'(ADDR_RULE_BASE) + 2 * int'(r) + 1), mask);
      m_pat[r]  = pat;
      m_mask[r] = mask;
   endtask

   task automatic arm(logic trig_en, logic [3:0] en);
      m_en = en;
      reg_wr(ADDR_CTRL, {22'd0, 1'b1, trig_en, 4'd0, en});
      arm_edge       = last_wr_edge;
      first_hit_edge = -1;
      m_ovf          = 1'b0;
      exp_ev.delete();
      rise_q.delete();
      width_q.delete();
   endtask

   task automatic send_nibble(trace_nibble_t nib);
      int hit;
      @(posedge trace_clk);
      #2;
      trcena     = 1'b1;
      trace_data = nib;
      m_buf      = {m_buf[27:0], nib};
      hit        = model_match(m_buf);
      if (hit >= 0) begin
         if (first_hit_edge < 0) first_hit_edge = cyc + 1;
         if (exp_ev.size() < DEPTH) begin
            exp_ev.push_back('{rule: rule_idx_t'(hit), tstamp: tstamp_t'(cyc + 2 - arm_edge)});
         end else begin
            m_ovf = 1'b1;                              // full, entry dropped
         end
      end
   endtask

   task automatic send_filler();
      trace_nibble_t nib;
      do begin
         nib = trace_nibble_t'($random(seed));
      end while (model_match({m_buf[27:0], nib}) >= 0);
      send_nibble(nib);
   endtask

   task automatic send_seq(trace_buf_t seq);
      for (int j = 0; j < 8; j++) send_nibble(seq[31 - 4 * j -: 4]);
   endtask

   task automatic stop_trace();
      @(posedge trace_clk);
      #2;
      trcena = 1'b0;
   endtask

   // count, empty and overflow against the model
   task automatic check_status(string what);
      reg_data_t d;
      reg_rd(ADDR_STATUS, d);
      check_data(what, d,
                 {21'd0, 1'b0, m_ovf, exp_ev.size() == 0, 2'd0, 6'(exp_ev.size())});
   endtask

   task automatic check_fifo();
      reg_data_t d;
      check_status("status before readout");
      while (exp_ev.size() > 0) begin
         reg_rd(ADDR_EVENT, d);
         check_data("event upper bits", d & 32'hFFFC_0000, 32'h0);
         check_event(trace_event_t'(d[17:0]), exp_ev.pop_front());
      end
      reg_rd(ADDR_EVENT, d);
      check_data("event read when empty", d, 32'h0);
      reg_rd(ADDR_STATUS, d);
      check_data("status after readout", d, {22'd0, m_ovf, 1'b1, 8'd0});
   endtask

   task automatic check_pulses(row_t t);
      int n_exp;
      int exp_rise;
      n_exp = (t.trig_en && t.npulses != 0 && first_hit_edge >= 0) ? int'(t.npulses) : 0;
      check_trig("pulse count", '0, trig_count_t'(rise_q.size()), trig_count_t'(n_exp));
      for (int p = 0; p < n_exp; p++) begin
         exp_rise = int'(t.delay) + 2 + p * (int'(t.width) + int'(t.delay));
         check_trig("rise edge after match", pulse_num_t'(p),
                    trig_count_t'(rise_q[p] - first_hit_edge), trig_count_t'(exp_rise));
         check_trig("pulse width", pulse_num_t'(p), trig_count_t'(width_q[p]), t.width);
      end
   endtask

   task automatic check_resets();
      reg_data_t d;
      reg_data_t v;
      for (int a = 0; a < 16; a++) begin
         reg_rd(reg_addr_t'(a), d);
         check_data($sformatf("reset value at %0d", a), d,
                    (a == int'(ADDR_STATUS)) ? 32'h100 : 32'h0);   // empty after reset
      end
      for (int i = 0; i < RULES; i++) begin
         v = $random(seed);
         d = $random(seed);
         set_rule(rule_idx_t'(i), v, d);
         reg_rd(reg_addr_t'(int'(ADDR_RULE_BASE) + 2 * i), v);
         check_data("pattern readback", v, m_pat[i]);
         reg_rd(reg_addr_t'(int'(ADDR_RULE_BASE) + 2 * i + 1), d);
         check_data("mask readback", d, m_mask[i]);
      end
      v = $random(seed);
      reg_wr(ADDR_TRIG_DELAY, v);
      reg_rd(ADDR_TRIG_DELAY, d);
      check_data("delay readback", d, v & 32'h000F_FFFF);
      reg_wr(ADDR_TRIG_WIDTH, ~v);
      reg_rd(ADDR_TRIG_WIDTH, d);
      check_data("width readback", d, ~v & 32'h000F_FFFF);
      reg_wr(ADDR_NUM_PULSES, v);
      reg_rd(ADDR_NUM_PULSES, d);
      check_data("pulse count readback", d, v & 32'h0000_000F);
      for (int a = 6; a < 8; a++) begin
         reg_wr(reg_addr_t'(a), 32'hFFFF_FFFF);
         reg_rd(reg_addr_t'(a), d);
         check_data("unmapped read", d, 32'h0);
      end
   endtask

   initial begin
      seed         = 32'h396f383c;
      errors       = 0;
      rst_n        = 1'b0;
      trcena       = 1'b0;
      trace_data   = '0;
      reg_write    = 1'b0;
      reg_read     = 1'b0;
      reg_addr     = '0;
      reg_wdata    = '0;
      trig_prev    = 1'b0;
      m_buf        = '0;
      m_en         = '0;
      m_ovf        = 1'b0;
      arm_edge     = 0;
      last_wr_edge = 0;
      first_hit_edge = -1;
      for (int i = 0; i < RULES; i++) begin
         m_pat[i]  = '0;
         m_mask[i] = '0;
      end
      repeat (16) @(posedge trace_clk);
      #2 rst_n = 1'b1;

      check_resets();
      for (int r = 0; r < NUM_ROWS; r++) begin
         set_rule(ROWS[r].ra, ROWS[r].pa, ROWS[r].ma);
         set_rule(ROWS[r].rb, ROWS[r].pb, ROWS[r].mb);
         reg_wr(ADDR_TRIG_DELAY, reg_data_t'(ROWS[r].delay));
         reg_wr(ADDR_TRIG_WIDTH, reg_data_t'(ROWS[r].width));
         reg_wr(ADDR_NUM_PULSES, reg_data_t'(ROWS[r].npulses));
         arm(ROWS[r].trig_en, ROWS[r].en);
         repeat (6) send_filler();
         for (int k = 0; k < ROWS[r].reps; k++) begin
            send_seq(ROWS[r].seq);
            repeat (ROWS[r].gap) send_filler();
         end
         stop_trace();
         repeat ((int'(ROWS[r].delay) + int'(ROWS[r].width)) * int'(ROWS[r].npulses)
                 + int'(ROWS[r].delay) + 8) @(posedge trace_clk);
         if (exp_ev.size() != ROWS[r].exp_events) begin
            fail_now($sformatf("row %0d: model predicts %0d events, table %0d",
                               r, exp_ev.size(), ROWS[r].exp_events));
         end
         if (exp_ev.size() > 0 && exp_ev[0].rule != ROWS[r].exp_rule) begin
            fail_now($sformatf("row %0d: model rule differs from table", r));
         end
         check_pulses(ROWS[r]);
         check_fifo();
      end

      // overflow, more matches than the FIFO holds
      set_rule(2'd0, 32'h1357_9BDF, 32'hFFFF_FFFF);
      arm(1'b0, 4'b0001);
      repeat (DEPTH + 3) begin
         repeat (2) send_filler();
         send_seq(32'h1357_9BDF);
      end
      stop_trace();
      repeat (4) @(posedge trace_clk);
      check_fifo();
      repeat (3) begin                                 // refill, overflow stays sticky
         repeat (2) send_filler();
         send_seq(32'h1357_9BDF);
      end
      stop_trace();
      repeat (4) @(posedge trace_clk);
      check_status("status before arm");
      arm(1'b0, 4'b0001);                              // clears count and overflow
      check_fifo();

      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
verilog/trace_pkg.sv
verilog/trace_regs.sv
verilog/trace_matcher.sv
verilog/event_capture.sv
verilog/pulse_trigger.sv
verilog/trace_top.sv
dv/trace_top_assert.sv
dv/trace_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the trace core simulation with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
   --top-module trace_top_tb -o trace_top_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "compile failed, see build.log"
   exit 1
fi

./obj_dir/trace_top_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
   echo "FAIL"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "FAIL, simulator returned $status"
   exit 1
fi
echo "PASS"
exit 0
